//--- design/dp_pkg.sv
package dp_pkg;

    localparam int NUM_REGS   = 16;
    localparam int SHAMT_BITS = 5;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  reg_addr_t;

    // data-processing opcode field values
    typedef enum logic [3:0] {
        OP_AND = 4'b0000,
        OP_EOR = 4'b0001,
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_ORR = 4'b1100,
        OP_MOV = 4'b1101
    } alu_op_t;

    typedef enum logic [1:0] {
        SH_LSL = 2'b00,
        SH_LSR = 2'b01,
        SH_ASR = 2'b10,
        SH_ROR = 2'b11
    } shift_t;

    // immediate form when i_bit is set
    typedef struct packed {
        logic [3:0] cond;
        logic [1:0] op;
        logic       i_bit;
        alu_op_t    opcode;
        logic       s;
        reg_addr_t  rn;
        reg_addr_t  rd;
        logic [3:0] rot;
        logic [7:0] imm8;
    } dp_imm_t;

    // register form with rs over shamt[4:1] when reg_shift is set
    typedef struct packed {
        logic [3:0]            cond;
        logic [1:0]            op;
        logic                  i_bit;
        alu_op_t               opcode;
        logic                  s;
        reg_addr_t             rn;
        reg_addr_t             rd;
        logic [SHAMT_BITS-1:0] shamt;
        shift_t                sh;
        logic                  reg_shift;
        reg_addr_t             rm;
    } dp_reg_t;

    typedef union packed {
        dp_imm_t i;
        dp_reg_t r;
    } dp_instr_t;

endpackage

//--- design/exec_if.sv
`timescale 1ns/10ps

// decoded operation from the operand stage to execute
interface exec_if;

    logic                          valid;
    dp_pkg::alu_op_t               op;
    dp_pkg::reg_addr_t             rd;
    logic                          use_shift;
    dp_pkg::word_t                 src_a;
    dp_pkg::word_t                 src_b;
    dp_pkg::word_t                 shift_val;
    dp_pkg::shift_t                sh;
    logic [dp_pkg::SHAMT_BITS-1:0] shamt;

    modport source (
        output valid, op, rd, use_shift, src_a, src_b, shift_val, sh, shamt
    );

    modport shifter (input shift_val, sh, shamt);

    modport alu (input op, src_a, src_b);

    modport combine (input valid, rd, use_shift);

endinterface

//--- design/reg_file.sv
`timescale 1ns/10ps

module reg_file (
    input  logic              clk,
    input  logic              reset,
    input  dp_pkg::reg_addr_t ra1,
    input  dp_pkg::reg_addr_t ra2,
    input  dp_pkg::reg_addr_t ra3,
    output dp_pkg::word_t     rd1,
    output dp_pkg::word_t     rd2,
    output dp_pkg::word_t     rd3,
    input  logic              we,
    input  dp_pkg::reg_addr_t wa,
    input  dp_pkg::word_t     wd
);

    dp_pkg::word_t regs [dp_pkg::NUM_REGS];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < dp_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wa] <= wd;
        end
    end

    // read ports for Rn, Rm and Rs
    assign rd1 = regs[ra1];
    assign rd2 = regs[ra2];
    assign rd3 = regs[ra3];

endmodule

//--- design/operand_stage.sv
`timescale 1ns/10ps

module operand_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  dp_pkg::dp_instr_t instr,
    input  logic              wb_valid,
    input  dp_pkg::reg_addr_t wb_rd,
    input  dp_pkg::word_t     wb_data,
    input  logic              fwd_valid,
    input  dp_pkg::reg_addr_t fwd_rd,
    input  dp_pkg::word_t     fwd_data,
    exec_if.source            ex
);

    dp_pkg::reg_addr_t rs_addr;
    dp_pkg::word_t     file_rn;
    dp_pkg::word_t     file_rm;
    dp_pkg::word_t     file_rs;
    dp_pkg::word_t     rn_val;
    dp_pkg::word_t     rm_val;
    dp_pkg::word_t     rs_val;
    logic              supported;
    logic              accept;

    assign rs_addr = instr.r.shamt[4:1];

    reg_file reg_file_u (
        .clk   (clk),
        .reset (reset),
        .ra1   (instr.i.rn),
        .ra2   (instr.r.rm),
        .ra3   (rs_addr),
        .rd1   (file_rn),
        .rd2   (file_rm),
        .rd3   (file_rs),
        .we    (wb_valid),
        .wa    (wb_rd),
        .wd    (wb_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // operand bypass

    // execute result wins over the write-back word not yet in the file
    function automatic dp_pkg::word_t bypass(input dp_pkg::reg_addr_t addr,
                                             input dp_pkg::word_t     file_val);
        if (fwd_valid && fwd_rd == addr) begin
            return fwd_data;
        end
        if (wb_valid && wb_rd == addr) begin
            return wb_data;
        end
        return file_val;
    endfunction

    always_comb begin
        rn_val = bypass(instr.i.rn, file_rn);
        rm_val = bypass(instr.r.rm, file_rm);
        rs_val = bypass(rs_addr, file_rs);
    end

    // only data-processing class with a listed opcode
    always_comb begin
        supported = 1'b0;
        if (instr.i.op == 2'b00) begin
            case (instr.i.opcode)
                dp_pkg::OP_AND,
                dp_pkg::OP_EOR,
                dp_pkg::OP_SUB,
                dp_pkg::OP_ADD,
                dp_pkg::OP_ORR,
                dp_pkg::OP_MOV: supported = 1'b1;
                default:        supported = 1'b0;
            endcase
        end
    end

    assign accept = instr_valid && supported;

    ////////////////////////////////////////////////////////////////////////////
    // execute register

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ex.valid     <= 1'b0;
            ex.op        <= dp_pkg::OP_AND;
            ex.rd        <= '0;
            ex.use_shift <= 1'b0;
            ex.src_a     <= '0;
            ex.src_b     <= '0;
            ex.shift_val <= '0;
            ex.sh        <= dp_pkg::SH_LSL;
            ex.shamt     <= '0;
        end else begin
            ex.valid <= accept;
            if (accept) begin
                ex.op        <= instr.i.opcode;
                ex.rd        <= instr.i.rd;
                // shifter only for MOV register form
                ex.use_shift <= !instr.i.i_bit && instr.i.opcode == dp_pkg::OP_MOV;
                ex.src_a     <= rn_val;
                ex.src_b     <= instr.i.i_bit ? {24'b0, instr.i.imm8} : rm_val;
                ex.shift_val <= rm_val;
                ex.sh        <= instr.r.sh;
                ex.shamt     <= instr.r.reg_shift ? rs_val[dp_pkg::SHAMT_BITS-1:0]
                                                  : instr.r.shamt;
            end
        end
    end

endmodule

//--- design/shift_unit.sv
`timescale 1ns/10ps

module shift_unit (
    exec_if.shifter       ex,
    output dp_pkg::word_t shift_out
);

    // a right shift of the doubled word gives the rotate
    logic [63:0] rot_full;

    assign rot_full = {ex.shift_val, ex.shift_val} >> ex.shamt;

    always_comb begin
        case (ex.sh)
            dp_pkg::SH_LSL: begin
                shift_out = ex.shift_val << ex.shamt;
            end
            dp_pkg::SH_LSR: begin
                shift_out = ex.shift_val >> ex.shamt;
            end
            dp_pkg::SH_ASR: begin
                // sign fill
                shift_out = $signed(ex.shift_val) >>> ex.shamt;
            end
            dp_pkg::SH_ROR: begin
                shift_out = rot_full[31:0];
            end
            default: begin
                shift_out = ex.shift_val;
            end
        endcase
    end

endmodule

//--- design/alu_unit.sv
`timescale 1ns/10ps

module alu_unit (
    exec_if.alu           ex,
    output dp_pkg::word_t alu_out
);

    always_comb begin
        case (ex.op)
            dp_pkg::OP_AND: alu_out = ex.src_a & ex.src_b;
            dp_pkg::OP_EOR: alu_out = ex.src_a ^ ex.src_b;
            // wraps modulo 2^32
            dp_pkg::OP_SUB: alu_out = ex.src_a - ex.src_b;
            dp_pkg::OP_ADD: alu_out = ex.src_a + ex.src_b;
            dp_pkg::OP_ORR: alu_out = ex.src_a | ex.src_b;
            dp_pkg::OP_MOV: alu_out = ex.src_b;
            default:        alu_out = '0;
        endcase
    end

endmodule

//--- design/result_select.sv
`timescale 1ns/10ps

module result_select (
    input  logic              clk,
    input  logic              reset,
    exec_if.combine           ex,
    input  dp_pkg::word_t     shift_out,
    input  dp_pkg::word_t     alu_out,
    output logic              fwd_valid,
    output dp_pkg::reg_addr_t fwd_rd,
    output dp_pkg::word_t     fwd_data,
    output logic              wb_valid,
    output dp_pkg::reg_addr_t wb_rd,
    output dp_pkg::word_t     wb_data
);

    // combined result of the op in execute doubles as the forward
    assign fwd_data  = ex.use_shift ? shift_out : alu_out;
    assign fwd_valid = ex.valid;
    assign fwd_rd    = ex.rd;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wb_valid <= 1'b0;
            wb_rd    <= '0;
            wb_data  <= '0;
        end else begin
            wb_valid <= ex.valid;
            if (ex.valid) begin
                wb_rd   <= ex.rd;
                wb_data <= fwd_data;
            end
        end
    end

endmodule

//--- design/dp_core.sv
`timescale 1ns/10ps

module dp_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  dp_pkg::word_t     instr,
    output logic              result_valid,
    output dp_pkg::word_t     result,
    output dp_pkg::reg_addr_t result_rd
);

    exec_if ex ();

    logic              fwd_valid;
    dp_pkg::reg_addr_t fwd_rd;
    dp_pkg::word_t     fwd_data;
    dp_pkg::word_t     shift_out;
    dp_pkg::word_t     alu_out;

    operand_stage operand_stage_u (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb_valid    (result_valid),
        .wb_rd       (result_rd),
        .wb_data     (result),
        .fwd_valid   (fwd_valid),
        .fwd_rd      (fwd_rd),
        .fwd_data    (fwd_data),
        .ex          (ex.source)
    );

    // shifter and ALU side by side in execute
    shift_unit shift_unit_u (
        .ex        (ex.shifter),
        .shift_out (shift_out)
    );

    alu_unit alu_unit_u (
        .ex      (ex.alu),
        .alu_out (alu_out)
    );

    // write-back register doubles as the result ports
    result_select result_select_u (
        .clk       (clk),
        .reset     (reset),
        .ex        (ex.combine),
        .shift_out (shift_out),
        .alu_out   (alu_out),
        .fwd_valid (fwd_valid),
        .fwd_rd    (fwd_rd),
        .fwd_data  (fwd_data),
        .wb_valid  (result_valid),
        .wb_rd     (result_rd),
        .wb_data   (result)
    );

endmodule

//--- tests/dp_core_tb.sv
`timescale 1ns/10ps

module dp_core_tb;

    logic              clk;
    logic              reset;
    logic              instr_valid;
    dp_pkg::word_t     instr;
    logic              result_valid;
    dp_pkg::word_t     result;
    dp_pkg::reg_addr_t result_rd;

    // stimulus table with one entry per strobe
    string             t_desc   [64];
    dp_pkg::word_t     t_instr  [64];
    bit                t_result [64];
    dp_pkg::reg_addr_t t_rd     [64];
    dp_pkg::word_t     t_val    [64];
    int                t_group  [64];
    int                n_entries = 0;
    string             group_name [1:6] = '{"reset state", "alu ops", "shifts",
                                            "forwarding", "unsupported", "random"};

    // results still owed by the DUT in arrival order
    string             exp_desc [$];
    dp_pkg::reg_addr_t exp_rd   [$];
    dp_pkg::word_t     exp_val  [$];
    int                exp_edge [$];

    // falling edges since time zero
    int edges = 0;

    int errors = 0;
    int checks = 0;

    dp_core DUT (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result),
        .result_rd    (result_rd)
    );

    always #5 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // instruction encoding

    function automatic dp_pkg::word_t imm_op(input logic [3:0] opc, input dp_pkg::reg_addr_t rn,
                                             input dp_pkg::reg_addr_t rd, input logic [7:0] imm8);
        return {4'he, 2'b00, 1'b1, opc, 1'b0, rn, rd, 4'h0, imm8};
    endfunction

    function automatic dp_pkg::word_t reg_op(input logic [3:0] opc, input dp_pkg::reg_addr_t rn,
                                             input dp_pkg::reg_addr_t rd,
                                             input dp_pkg::reg_addr_t rm,
                                             input dp_pkg::shift_t sh, input logic [4:0] shamt);
        return {4'he, 2'b00, 1'b0, opc, 1'b0, rn, rd, shamt, sh, 1'b0, rm};
    endfunction

    // rs in [11:8] with bit 7 clear
    function automatic dp_pkg::word_t rs_op(input dp_pkg::reg_addr_t rd,
                                            input dp_pkg::reg_addr_t rm,
                                            input dp_pkg::shift_t sh, input dp_pkg::reg_addr_t rs);
        return {4'he, 2'b00, 1'b0, dp_pkg::OP_MOV, 1'b0, 4'h0, rd, rs, 1'b0, sh, 1'b1, rm};
    endfunction

    task automatic add_entry(input int group, input string desc, input dp_pkg::word_t ins,
                             input bit has_result, input dp_pkg::reg_addr_t rd,
                             input dp_pkg::word_t val);
        t_group[n_entries]  = group;
        t_desc[n_entries]   = desc;
        t_instr[n_entries]  = ins;
        t_result[n_entries] = has_result;
        t_rd[n_entries]     = rd;
        t_val[n_entries]    = val;
        n_entries++;
    endtask

    task automatic compare(input string what, input logic [31:0] actual,
                           input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic wait_drained();
        int cycles = 0;
        while (exp_val.size() > 0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_val.size() > 0) begin
            $display("timeout: %0d results never arrived from the DUT", exp_val.size());
            $display("Testbench failed");
            $finish;
        end
    endtask

    // result monitor samples away from the active edge
    always @(negedge clk) begin
        edges++;
        if (!reset && result_valid) begin
            if (exp_val.size() == 0) begin
                errors++;
                $display("unexpected result %h for r%0d at %0t ns", result, result_rd, $time);
            end else begin
                compare({exp_desc[0], " edge"}, edges, exp_edge.pop_front());
                compare({exp_desc[0], " rd"}, result_rd, exp_rd.pop_front());
                compare(exp_desc.pop_front(), result, exp_val.pop_front());
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus

    initial begin
        logic [7:0] a;
        logic [7:0] b;
        int         err_before;
        void'($urandom(32'h75cd));
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        a = $urandom % 256;
        b = $urandom % 256;

        add_entry(1, "mov r1 r0", reg_op(dp_pkg::OP_MOV, 0, 1, 0, dp_pkg::SH_LSL, 0), 1, 1, 0);

        add_entry(2, "mov r3 #5a", imm_op(dp_pkg::OP_MOV, 0, 3, 8'h5a), 1, 3, 32'h5a);
        add_entry(2, "mov r4 #0f", imm_op(dp_pkg::OP_MOV, 0, 4, 8'h0f), 1, 4, 32'h0f);
        add_entry(2, "and", reg_op(dp_pkg::OP_AND, 3, 5, 4, dp_pkg::SH_LSL, 0), 1, 5, 32'h0a);
        add_entry(2, "eor", reg_op(dp_pkg::OP_EOR, 3, 6, 4, dp_pkg::SH_LSL, 0), 1, 6, 32'h55);
        // 0x0f minus 0x5a wraps below zero
        add_entry(2, "sub", reg_op(dp_pkg::OP_SUB, 4, 7, 3, dp_pkg::SH_LSL, 0), 1, 7, 32'hffffffb5);
        add_entry(2, "add", reg_op(dp_pkg::OP_ADD, 3, 8, 4, dp_pkg::SH_LSL, 0), 1, 8, 32'h69);
        add_entry(2, "orr", reg_op(dp_pkg::OP_ORR, 3, 9, 4, dp_pkg::SH_LSL, 0), 1, 9, 32'h5f);
        add_entry(2, "add imm", imm_op(dp_pkg::OP_ADD, 3, 10, 8'hff), 1, 10, 32'h159);

        add_entry(3, "mov r11 #81", imm_op(dp_pkg::OP_MOV, 0, 11, 8'h81), 1, 11, 32'h81);
        add_entry(3, "neg r12", reg_op(dp_pkg::OP_SUB, 0, 12, 11, dp_pkg::SH_LSL, 0), 1, 12,
                  32'hffffff7f);
        add_entry(3, "lsl #4", reg_op(dp_pkg::OP_MOV, 0, 13, 3, dp_pkg::SH_LSL, 4), 1, 13, 32'h5a0);
        add_entry(3, "lsr #3", reg_op(dp_pkg::OP_MOV, 0, 13, 3, dp_pkg::SH_LSR, 3), 1, 13, 32'h0b);
        add_entry(3, "asr #4", reg_op(dp_pkg::OP_MOV, 0, 13, 12, dp_pkg::SH_ASR, 4), 1, 13,
                  32'hfffffff7);
        add_entry(3, "ror #4", reg_op(dp_pkg::OP_MOV, 0, 13, 3, dp_pkg::SH_ROR, 4), 1, 13,
                  32'ha0000005);
        add_entry(3, "lsl #0", reg_op(dp_pkg::OP_MOV, 0, 13, 3, dp_pkg::SH_LSL, 0), 1, 13, 32'h5a);
        // shift amount is the low 5 bits of 0x28 which is 8
        add_entry(3, "mov r14 #28", imm_op(dp_pkg::OP_MOV, 0, 14, 8'h28), 1, 14, 32'h28);
        add_entry(3, "lsl r14", rs_op(13, 3, dp_pkg::SH_LSL, 14), 1, 13, 32'h5a00);
        add_entry(3, "asr r14", rs_op(13, 12, dp_pkg::SH_ASR, 14), 1, 13, 32'hffffffff);
        add_entry(3, "ror r14", rs_op(13, 3, dp_pkg::SH_ROR, 14), 1, 13, 32'h5a000000);
        add_entry(3, "lsr r0", rs_op(13, 3, dp_pkg::SH_LSR, 0), 1, 13, 32'h5a);

        add_entry(4, "mov r2 #3", imm_op(dp_pkg::OP_MOV, 0, 2, 8'h03), 1, 2, 32'h3);
        add_entry(4, "add r2 1", reg_op(dp_pkg::OP_ADD, 2, 2, 2, dp_pkg::SH_LSL, 0), 1, 2, 32'h6);
        add_entry(4, "add r2 2", reg_op(dp_pkg::OP_ADD, 2, 2, 2, dp_pkg::SH_LSL, 0), 1, 2, 32'hc);
        add_entry(4, "add r2 3", reg_op(dp_pkg::OP_ADD, 2, 2, 2, dp_pkg::SH_LSL, 0), 1, 2, 32'h18);
        add_entry(4, "fwd rm", reg_op(dp_pkg::OP_MOV, 0, 1, 2, dp_pkg::SH_LSL, 1), 1, 1, 32'h30);
        add_entry(4, "mov r14 #2", imm_op(dp_pkg::OP_MOV, 0, 14, 8'h02), 1, 14, 32'h2);
        add_entry(4, "fwd rs", rs_op(1, 2, dp_pkg::SH_LSL, 14), 1, 1, 32'h60);
        add_entry(4, "fwd rn", reg_op(dp_pkg::OP_ORR, 1, 1, 4, dp_pkg::SH_LSL, 0), 1, 1, 32'h6f);

        add_entry(5, "op 01", imm_op(dp_pkg::OP_MOV, 0, 9, 8'h11) | 32'h0400_0000, 0, 0, 0);
        add_entry(5, "opcode 0011", imm_op(4'b0011, 0, 9, 8'h22), 0, 0, 0);
        add_entry(5, "mov r5 #33", imm_op(dp_pkg::OP_MOV, 0, 5, 8'h33), 1, 5, 32'h33);
        add_entry(5, "r9 kept", reg_op(dp_pkg::OP_ORR, 9, 6, 0, dp_pkg::SH_LSL, 0), 1, 6, 32'h5f);

        add_entry(6, "mov r1 rand", imm_op(dp_pkg::OP_MOV, 0, 1, a), 1, 1, {24'b0, a});
        add_entry(6, "mov r2 rand", imm_op(dp_pkg::OP_MOV, 0, 2, b), 1, 2, {24'b0, b});
        add_entry(6, "add rand", reg_op(dp_pkg::OP_ADD, 1, 3, 2, dp_pkg::SH_LSL, 0), 1, 3,
                  32'(a) + 32'(b));
        add_entry(6, "eor rand", reg_op(dp_pkg::OP_EOR, 1, 4, 2, dp_pkg::SH_LSL, 0), 1, 4,
                  {24'b0, a ^ b});
        add_entry(6, "sub rand", reg_op(dp_pkg::OP_SUB, 1, 5, 2, dp_pkg::SH_LSL, 0), 1, 5,
                  32'(a) - 32'(b));

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);

        for (int g = 1; g <= 6; g++) begin
            err_before = errors;
            for (int i = 0; i < n_entries; i++) begin
                if (t_group[i] == g) begin
                    @(posedge clk);
                    instr_valid <= 1'b1;
                    instr       <= t_instr[i];
                    if (t_result[i]) begin
                        exp_desc.push_back(t_desc[i]);
                        exp_rd.push_back(t_rd[i]);
                        exp_val.push_back(t_val[i]);
                        // result strobe two rising edges after this one
                        exp_edge.push_back(edges + 3);
                    end
                end
            end
            @(posedge clk);
            instr_valid <= 1'b0;
            wait_drained();
            // idle cycles catch any stray strobe
            repeat (3) @(posedge clk);
            $display("test %0d %s: %s", g, group_name[g], errors == err_before ? "ok" : "mismatch");
        end

        $display("6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- src.f
design/dp_pkg.sv
design/exec_if.sv
design/reg_file.sv
design/operand_stage.sv
design/shift_unit.sv
design/alu_unit.sv
design/result_select.sv
design/dp_core.sv
tests/dp_core_tb.sv

//--- Bender.yml
package:
  name: dp_core

sources:
  - design/dp_pkg.sv
  - design/exec_if.sv
  - design/reg_file.sv
  - design/operand_stage.sv
  - design/shift_unit.sv
  - design/alu_unit.sv
  - design/result_select.sv
  - design/dp_core.sv
  - target: test
    files:
      - tests/dp_core_tb.sv
